/* common/overlay_pkg.sv */
// ==============================
// shared types for the tile overlay
// entity fields are fixed; slot kinds depend only on the slot index
// ==============================
`default_nettype none

package overlay_pkg;

    typedef logic [9:0]  pix_t;
    // pixel coordinate with headroom for array footprints
    typedef logic [10:0] span_t;
    typedef logic [17:0] entity_t;
    typedef logic [3:0]  slot_t;
    typedef logic [3:0]  ent_id_t;
    typedef logic [1:0]  orient_t;
    typedef logic [2:0]  row_t;
    // row, id, orientation
    typedef logic [8:0]  tile_word_t;

    // entity field positions
    localparam int ID_HI  = 17;
    localparam int ID_LO  = 14;
    localparam int OR_HI  = 13;
    localparam int OR_LO  = 12;
    localparam int TX_HI  = 11;
    localparam int TX_LO  = 8;
    localparam int TY_HI  = 7;
    localparam int TY_LO  = 4;
    localparam int LEN_HI = 3;
    localparam int LEN_LO = 0;

    localparam int         TILE_ROWS = 8;
    localparam int         NUM_SLOTS = 9;
    localparam ent_id_t    ID_UNUSED = 4'd15;
    localparam tile_word_t TILE_NONE = '1;
    localparam entity_t    ENTITY_UNUSED = {ID_UNUSED, 14'd0};

    localparam orient_t ORIENT_DOWN  = 2'd0;
    localparam orient_t ORIENT_LEFT  = 2'd1;
    localparam orient_t ORIENT_UP    = 2'd2;
    localparam orient_t ORIENT_RIGHT = 2'd3;

    localparam slot_t SLOT_ARRAY      = 4'd6;
    localparam slot_t SLOT_FLIP_FIRST = 4'd7;

    typedef enum logic [1:0] {KIND_PLAIN, KIND_ARRAY, KIND_FLIP} slot_kind_t;
    typedef enum logic [1:0] {SWEEP_IDLE, SWEEP_RUN, SWEEP_DONE} sweep_state_t;

    function automatic slot_kind_t slot_kind(slot_t idx);
        if (idx == SLOT_ARRAY) return KIND_ARRAY;
        if (idx >= SLOT_FLIP_FIRST) return KIND_FLIP;
        return KIND_PLAIN;
    endfunction

endpackage

`default_nettype wire

/* common/scan_if.sv */
// ==============================
// one slot entity per valid cycle, paired
// with the probe of the next tile
// ==============================
`timescale 1ns/1ps
`default_nettype none

interface scan_if
    import overlay_pkg::*;
();

    slot_t   slot_sel;
    entity_t entity;
    pix_t    probe_h;
    pix_t    probe_v;
    logic    valid;

    modport sweep (output slot_sel, output valid);

    modport slots (input slot_sel, output entity);

    modport timer (output probe_h, output probe_v);

    // observer only
    modport detector (input slot_sel, input entity, input probe_h, input probe_v, input valid);

endinterface

`default_nettype wire

/* design/entity_slots.sv */
// ==============================
// Wishbone classic slave, single cycles only
// addresses 9 to 15 ack, read zero, drop writes
// ==============================
`timescale 1ns/1ps
`default_nettype none

module entity_slots
    import overlay_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    wb_cyc,
    input  wire logic    wb_stb,
    input  wire logic    wb_we,
    input  wire slot_t   wb_adr,
    input  wire entity_t wb_dat_w,
    output entity_t      wb_dat_r,
    output logic         wb_ack,
    scan_if.slots        scan
);

    entity_t slots [NUM_SLOTS];
    logic    req;
    logic    adr_ok;

    assign req    = wb_cyc && wb_stb;
    assign adr_ok = wb_adr < slot_t'(NUM_SLOTS);

    // ack one cycle after the request, then drop for at least one cycle
    always_ff @(posedge clk) begin
        if (!reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req && !wb_ack;
        end
    end

    // write lands on the ack edge
    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i] <= ENTITY_UNUSED;
            end
        end else if (wb_ack && req && wb_we && adr_ok) begin
            slots[wb_adr] <= wb_dat_w;
        end
    end

    assign wb_dat_r = adr_ok ? slots[wb_adr] : '0;

    // sweep side
    assign scan.entity = (scan.slot_sel < slot_t'(NUM_SLOTS)) ? slots[scan.slot_sel]
                                                              : ENTITY_UNUSED;

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!reset)
        wb_ack |=> !wb_ack
    );

endmodule

`default_nettype wire

/* design/tile_timer.sv */
// ==============================
// counter_h must step by one per clock and
// pass through 0 before the first valid tile
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tile_timer
    import overlay_pkg::*;
#(
    parameter int UPSCALE = 5,
    parameter int TILES_H = 16
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire pix_t counter_h,
    input  wire pix_t counter_v,
    output logic      tile_start,
    scan_if.timer     scan
);

    localparam pix_t TILE_LEN    = pix_t'(TILE_ROWS * UPSCALE);
    localparam pix_t VISIBLE_W   = pix_t'(TILE_ROWS * UPSCALE * TILES_H);
    localparam pix_t LAST_TILE_H = VISIBLE_W - TILE_LEN;

    pix_t in_tile_q;
    pix_t in_tile;
    logic boundary;
    pix_t probe_h_q;
    pix_t probe_v_q;

    // position of the current counter_h inside its tile
    always_comb begin
        if (counter_h == '0) begin
            in_tile = '0;
        end else if (in_tile_q == TILE_LEN - pix_t'(1)) begin
            in_tile = '0;
        end else begin
            in_tile = in_tile_q + pix_t'(1);
        end
    end

    assign boundary = (in_tile == '0) && (counter_h < VISIBLE_W);

    always_ff @(posedge clk) begin
        if (!reset) begin
            in_tile_q  <= '0;
            tile_start <= 1'b0;
        end else begin
            in_tile_q  <= in_tile;
            tile_start <= boundary;
        end
    end

    // look ahead one tile, last tile wraps to column 0 of the next line
    always_ff @(posedge clk) begin
        if (boundary) begin
            if (counter_h >= LAST_TILE_H) begin
                probe_h_q <= '0;
                probe_v_q <= counter_v + pix_t'(1);
            end else begin
                probe_h_q <= counter_h + TILE_LEN;
                probe_v_q <= counter_v;
            end
        end
    end

    assign scan.probe_h = probe_h_q;
    assign scan.probe_v = probe_v_q;

    tile_start_pulse: assert property (
        @(posedge clk) disable iff (!reset)
        tile_start |=> !tile_start
    );

endmodule

`default_nettype wire

/* design/sweep_fsm.sv */
// ==============================
// one pass over all slots per tile_start
// a tile_start during a pass is ignored
// ==============================
`timescale 1ns/1ps
`default_nettype none

module sweep_fsm
    import overlay_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic tile_start,
    scan_if.sweep     scan
);

    sweep_state_t state;
    sweep_state_t state_next;
    slot_t        slot_q;
    logic         valid_q;

    always_comb begin
        state_next = state;
        case (state)
            SWEEP_IDLE: begin
                if (tile_start) state_next = SWEEP_RUN;
            end
            SWEEP_RUN: begin
                // slot 0 is the last one out
                if (slot_q == '0) state_next = SWEEP_DONE;
            end
            SWEEP_DONE: begin
                state_next = SWEEP_IDLE;
            end
            default: begin
                state_next = SWEEP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state   <= SWEEP_IDLE;
            slot_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            state <= state_next;
            if (state == SWEEP_IDLE && tile_start) begin
                slot_q  <= slot_t'(NUM_SLOTS - 1);
                valid_q <= 1'b1;
            end else if (state == SWEEP_RUN && slot_q != '0) begin
                slot_q <= slot_q - slot_t'(1);
            end else if (state == SWEEP_RUN) begin
                valid_q <= 1'b0;
            end
        end
    end

    assign scan.slot_sel = slot_q;
    assign scan.valid    = valid_q;

    no_valid_in_idle: assert property (
        @(posedge clk) disable iff (!reset)
        (state == SWEEP_IDLE) |-> !valid_q
    );

    // the sweep has to finish within one tile
    sweep_fits_tile: assert property (
        @(posedge clk) disable iff (!reset)
        tile_start |-> (state == SWEEP_IDLE)
    );

endmodule

`default_nettype wire

/* entity_detector/entity_detector.sv */
// ==============================
// hits land in the holder 4 cycles after valid
// sweep and pipeline must end before the next tile_start
// ==============================
`timescale 1ns/1ps
`default_nettype none

module entity_detector
    import overlay_pkg::*;
#(
    parameter int UPSCALE = 5
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic tile_start,
    scan_if.detector  scan,
    output tile_word_t out_tile
);

    localparam span_t TILE_LEN = span_t'(TILE_ROWS * UPSCALE);
    localparam pix_t  TILE_LEN_PIX = pix_t'(TILE_ROWS * UPSCALE);

    // stage 1
    logic       valid_1;
    ent_id_t    id_1;
    orient_t    orient_1;
    logic [3:0] len_1;
    slot_kind_t kind_1;
    span_t      org_h_1;
    span_t      org_v_1;

    // stage 2
    logic       valid_2;
    ent_id_t    id_2;
    orient_t    orient_2;
    slot_kind_t kind_2;
    span_t      ext;
    span_t      lo_h;
    span_t      hi_h;
    span_t      lo_v;
    span_t      hi_v;
    span_t      lo_h_2;
    span_t      hi_h_2;
    span_t      lo_v_2;
    span_t      hi_v_2;

    // stage 3
    logic       hit_3;
    ent_id_t    id_3;
    orient_t    orient_3;
    logic       flip_3;
    pix_t       offs_3;

    // stage 4 and result
    row_t       row_4;
    tile_word_t holder;

    assign ext = span_t'(len_1) * TILE_LEN;

    // footprint, arrays grow toward their orientation
    always_comb begin
        lo_h = org_h_1;
        hi_h = org_h_1 + TILE_LEN;
        lo_v = org_v_1;
        hi_v = org_v_1 + TILE_LEN;
        if (kind_1 == KIND_ARRAY) begin
            case (orient_1)
                ORIENT_DOWN:  hi_v = hi_v + ext;
                ORIENT_LEFT:  lo_h = (ext > org_h_1) ? '0 : org_h_1 - ext;
                ORIENT_UP:    lo_v = (ext > org_v_1) ? '0 : org_v_1 - ext;
                ORIENT_RIGHT: hi_h = hi_h + ext;
                default:      hi_h = hi_h;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            valid_1 <= 1'b0;
            valid_2 <= 1'b0;
            hit_3   <= 1'b0;
        end else begin
            valid_1 <= scan.valid;
            valid_2 <= valid_1;
            hit_3   <= valid_2 && (id_2 != ID_UNUSED)
                       && (span_t'(scan.probe_h) >= lo_h_2) && (span_t'(scan.probe_h) < hi_h_2)
                       && (span_t'(scan.probe_v) >= lo_v_2) && (span_t'(scan.probe_v) < hi_v_2);
        end
    end

    always_ff @(posedge clk) begin
        id_1     <= scan.entity[ID_HI:ID_LO];
        orient_1 <= scan.entity[OR_HI:OR_LO];
        len_1    <= scan.entity[LEN_HI:LEN_LO];
        kind_1   <= slot_kind(scan.slot_sel);
        org_h_1  <= span_t'(scan.entity[TX_HI:TX_LO]) * TILE_LEN;
        org_v_1  <= span_t'(scan.entity[TY_HI:TY_LO]) * TILE_LEN;

        id_2     <= id_1;
        orient_2 <= orient_1;
        kind_2   <= kind_1;
        lo_h_2   <= lo_h;
        hi_h_2   <= hi_h;
        lo_v_2   <= lo_v;
        hi_v_2   <= hi_v;

        id_3     <= id_2;
        orient_3 <= orient_2;
        flip_3   <= (kind_2 == KIND_FLIP);
        offs_3   <= scan.probe_v % TILE_LEN_PIX;
    end

    // bitmap row of the scanline inside the tile
    assign row_4 = flip_3 ? ~row_t'(offs_3 / pix_t'(UPSCALE)) : row_t'(offs_3 / pix_t'(UPSCALE));

    // later hits overwrite, so the lowest slot wins
    always_ff @(posedge clk) begin
        if (!reset) begin
            holder   <= TILE_NONE;
            out_tile <= TILE_NONE;
        end else if (tile_start) begin
            out_tile <= holder;
            holder   <= TILE_NONE;
        end else if (hit_3) begin
            holder <= {row_4, id_3, orient_3};
        end
    end

    pipeline_drained: assert property (
        @(posedge clk) disable iff (!reset)
        tile_start |-> !(scan.valid || valid_1 || valid_2 || hit_3)
    );

endmodule

`default_nettype wire

/* design/tile_overlay_top.sv */
// ==============================
// counter_h/counter_v come from external VGA timing
// out_tile is the result for the current tile
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tile_overlay_top
    import overlay_pkg::*;
#(
    parameter int UPSCALE = 5,
    parameter int TILES_H = 16
) (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    wb_cyc,
    input  wire logic    wb_stb,
    input  wire logic    wb_we,
    input  wire slot_t   wb_adr,
    input  wire entity_t wb_dat_w,
    output entity_t      wb_dat_r,
    output logic         wb_ack,
    input  wire pix_t    counter_h,
    input  wire pix_t    counter_v,
    output tile_word_t   out_tile
);

    logic tile_start;

    scan_if scan ();

    entity_slots slots_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .scan     (scan.slots)
    );

    tile_timer #(.UPSCALE(UPSCALE), .TILES_H(TILES_H)) timer_i (
        .clk        (clk),
        .reset      (reset),
        .counter_h  (counter_h),
        .counter_v  (counter_v),
        .tile_start (tile_start),
        .scan       (scan.timer)
    );

    sweep_fsm sweep_i (
        .clk        (clk),
        .reset      (reset),
        .tile_start (tile_start),
        .scan       (scan.sweep)
    );

    entity_detector #(.UPSCALE(UPSCALE)) detector_i (
        .clk        (clk),
        .reset      (reset),
        .tile_start (tile_start),
        .scan       (scan.detector),
        .out_tile   (out_tile)
    );

endmodule

`default_nettype wire

/* tb/tb_tile_overlay.sv */
// ==============================
// directed tests against a reference model
// DUT runs with UPSCALE 5, TILES_H 16, 800 clocks per line
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_tile_overlay
    import overlay_pkg::*;
();

    localparam int UPSCALE     = 5;
    localparam int TILES_H     = 16;
    localparam int TILE_LEN    = TILE_ROWS * UPSCALE;
    localparam int VISIBLE_W   = TILE_LEN * TILES_H;
    localparam int H_TOTAL     = 800;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int ACK_LIMIT   = 16;
    localparam int TEST_LINES  = 60;
    localparam int TIMEOUT_CYC = TEST_LINES * H_TOTAL + 4000;
    localparam int ARRAY_SLOT  = 6;
    localparam int FLIP_FIRST  = 7;

    logic       clk = 1'b0;
    logic       reset;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    slot_t      wb_adr;
    entity_t    wb_dat_w;
    entity_t    wb_dat_r;
    logic       wb_ack;
    pix_t       counter_h;
    pix_t       counter_v;
    tile_word_t out_tile;

    // expected slot contents
    entity_t model [NUM_SLOTS];
    int      errors = 0;
    int      checks = 0;
    int      last_v = -10;
    bit      wrap_valid = 1'b0;
    int      seed_val;

    tile_overlay_top #(.UPSCALE(UPSCALE), .TILES_H(TILES_H)) dut_i (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .counter_h (counter_h),
        .counter_v (counter_v),
        .out_tile  (out_tile)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic entity_t make_entity(input int id, input int ori, input int tx,
                                            input int ty, input int len);
        entity_t e;
        e = '0;
        e[17:14] = id[3:0];
        e[13:12] = ori[1:0];
        e[11:8]  = tx[3:0];
        e[7:4]   = ty[3:0];
        e[3:0]   = len[3:0];
        return e;
    endfunction

    // first covering slot from 0 upward wins
    function automatic tile_word_t expected_tile(input int ph, input int pv);
        logic [3:0] id;
        logic [1:0] ori;
        logic [2:0] row_bits;
        int col;
        int row;
        int tx;
        int ty;
        int len;
        int lo_x;
        int hi_x;
        int lo_y;
        int hi_y;
        int pix_row;
        col = ph / TILE_LEN;
        row = pv / TILE_LEN;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            id  = model[s][17:14];
            ori = model[s][13:12];
            tx  = model[s][11:8];
            ty  = model[s][7:4];
            len = model[s][3:0];
            lo_x = tx;
            hi_x = tx;
            lo_y = ty;
            hi_y = ty;
            if (s == ARRAY_SLOT) begin
                case (ori)
                    2'd0: hi_y = ty + len;
                    2'd1: lo_x = tx - len;
                    2'd2: lo_y = ty - len;
                    default: hi_x = tx + len;
                endcase
            end
            if (id != ID_UNUSED && col >= lo_x && col <= hi_x && row >= lo_y && row <= hi_y) begin
                pix_row = (pv % TILE_LEN) / UPSCALE;
                if (s >= FLIP_FIRST) pix_row = TILE_ROWS - 1 - pix_row;
                row_bits = pix_row[2:0];
                return {row_bits, id, ori};
            end
        end
        return TILE_NONE;
    endfunction

    task automatic check_tile(input tile_word_t got, input tile_word_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t ns: %s: out_tile %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_entity(input entity_t got, input entity_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t ns: %s: read %h, expected %h", $time, what, got, want);
        end
    endtask

    // single classic cycle, stb held until the ack edge
    task automatic wb_cycle(input bit we, input slot_t adr, input entity_t wdata,
                            output entity_t rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            errors++;
            $display("wishbone cycle to address %0d was never acknowledged", adr);
        end
        rdata = wb_dat_r;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (wb_ack) begin
            errors++;
            $display("wb_ack stayed high for two cycles at address %0d", adr);
        end
    endtask

    task automatic wb_write(input int adr, input entity_t data);
        entity_t unused_r;
        wb_cycle(1'b1, slot_t'(adr), data, unused_r);
        if (adr < NUM_SLOTS) model[adr] = data;
        wrap_valid = 1'b0;
    endtask

    task automatic wb_read(input int adr, output entity_t data);
        wb_cycle(1'b0, slot_t'(adr), '0, data);
    endtask

    task automatic clear_slots();
        for (int i = 0; i < NUM_SLOTS; i++) begin
            wb_write(i, make_entity(15, 0, 0, 0, 0));
        end
    endtask

    task automatic verify_slots(input string what);
        entity_t rd;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            wb_read(i, rd);
            check_entity(rd, model[i], $sformatf("%s slot %0d", what, i));
        end
    endtask

    // one full line, every tile sampled in its middle
    task automatic scan_line(input int v);
        int col;
        for (int h = 0; h < H_TOTAL; h++) begin
            counter_h = pix_t'(h);
            counter_v = pix_t'(v);
            if (h < VISIBLE_W && h % TILE_LEN == TILE_LEN / 2) begin
                col = h / TILE_LEN;
                // tile 0 comes from the wrapped probe of the line before
                if (col != 0 || (wrap_valid && v == last_v + 1)) begin
                    check_tile(out_tile, expected_tile(col * TILE_LEN, v),
                               $sformatf("line %0d tile %0d", v, col));
                end
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        last_v     = v;
        wrap_valid = 1'b1;
    endtask

    task automatic after_reset_state();
        verify_slots("after reset");
        scan_line(0);
        scan_line(1);
        scan_line(300);
    endtask

    task automatic register_access();
        entity_t rd;
        int adr;
        repeat (12) begin
            wb_write($urandom_range(NUM_SLOTS - 1, 0), entity_t'($urandom));
        end
        verify_slots("random write");
        adr = $urandom_range(15, NUM_SLOTS);
        wb_write(adr, entity_t'($urandom));
        verify_slots("out of range write");
        wb_read(adr, rd);
        check_entity(rd, '0, $sformatf("address %0d", adr));
        // random slot contents through the whole scan path
        scan_line($urandom_range(600, 0));
    endtask

    task automatic plain_entity();
        int ty;
        ty = $urandom_range(14, 1);
        clear_slots();
        wb_write($urandom_range(5, 0), make_entity($urandom_range(14, 0), $urandom_range(3, 0),
                                                   $urandom_range(15, 0), ty, 0));
        scan_line(ty * TILE_LEN - 1);
        scan_line(ty * TILE_LEN);
        scan_line(ty * TILE_LEN + $urandom_range(38, 1));
        scan_line(ty * TILE_LEN + TILE_LEN - 1);
        scan_line(ty * TILE_LEN + TILE_LEN);
    endtask

    task automatic flipped_entity();
        int ty;
        ty = $urandom_range(14, 0);
        clear_slots();
        wb_write($urandom_range(8, 7), make_entity($urandom_range(14, 0), $urandom_range(3, 0),
                                                   $urandom_range(15, 0), ty, 0));
        scan_line(ty * TILE_LEN);
        scan_line(ty * TILE_LEN + 12);
        scan_line(ty * TILE_LEN + TILE_LEN - 1);
    endtask

    task automatic array_footprint();
        for (int ori = 0; ori < 4; ori++) begin
            clear_slots();
            wb_write(ARRAY_SLOT, make_entity($urandom_range(14, 0), ori, 7, 7,
                                             $urandom_range(3, 1)));
            for (int row = 3; row <= 11; row++) begin
                scan_line(row * TILE_LEN + TILE_LEN / 2);
            end
        end
    endtask

    task automatic overlap_and_wrap();
        int tx;
        int ty;
        tx = $urandom_range(14, 1);
        ty = $urandom_range(14, 1);
        clear_slots();
        wb_write(8, make_entity(11, 3, tx, ty, 0));
        wb_write(5, make_entity(7, 2, tx, ty, 0));
        wb_write(ARRAY_SLOT, make_entity(12, 3, tx - 1, ty, 2));
        wb_write(2, make_entity(4, 1, tx, ty, 0));
        scan_line(ty * TILE_LEN + 8);
        wb_write(2, make_entity(15, 0, 0, 0, 0));
        scan_line(ty * TILE_LEN + 30);
        // entities on tile column 0, reached through the line end probe
        clear_slots();
        wb_write(4, make_entity(3, 0, 0, 5, 0));
        wb_write(1, make_entity(9, 2, 0, 5, 0));
        scan_line(5 * TILE_LEN - 1);
        scan_line(5 * TILE_LEN);
        scan_line(5 * TILE_LEN + 1);
    endtask

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("timeout: the tests did not finish in the expected time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed_val  = $urandom(39);
        reset     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        // parked outside the visible width
        counter_h = pix_t'(H_TOTAL - 1);
        counter_v = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            model[i] = make_entity(15, 0, 0, 0, 0);
        end
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;

        after_reset_state();
        register_access();
        plain_entity();
        flipped_entity();
        array_footprint();
        overlap_and_wrap();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
common/overlay_pkg.sv
common/scan_if.sv
design/entity_slots.sv
design/tile_timer.sv
design/sweep_fsm.sv
entity_detector/entity_detector.sv
design/tile_overlay_top.sv
tb/tb_tile_overlay.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tile_overlay
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
